//--- verif/capture_cases.txt
// one hex word per case: route lo, route hi, sample count (2 digits), ready mode
// ready mode 0 always high, 1 random, 2 held low through the frame
00080
11060
200A0
030C0
230F1
00142

//--- verilog.f
hdl/capture_pkg.sv
hdl/stream_pkg.sv
hdl/capture_framer.sv
hdl/sample_fifo.sv
hdl/stream_out_stage.sv
hdl/adc_capture_top.sv
verif/adc_capture_assert.sv
verif/tb_adc_capture.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_adc_capture -f verilog.f
out=$(./obj_dir/Vtb_adc_capture 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "All tests passed"; then
  exit 0
fi
echo "simulation did not pass"
exit 1

//--- verif/tb_adc_capture.sv
`timescale 1ns/1ns
`default_nettype none

module tb_adc_capture;

  localparam int MAX_CASES   = 16;
  localparam int CASE_CYCLES = 400;

  logic        clk_245_76MHz  = 1'b0;
  logic        cpu_reset      = 1'b1;
  logic        enable_i       = 1'b0;
  logic [7:0]  route_word_i   = 8'h00;
  logic [15:0] adc_i_i        = 16'h0000;
  logic [15:0] adc_q_i        = 16'h0000;
  logic [15:0] dac_i_i        = 16'h0000;
  logic [15:0] dac_q_i        = 16'h0000;
  logic        sample_valid_i = 1'b0;
  logic        out_ready_i    = 1'b0;
  wire  [63:0] out_data_o;
  wire         out_valid_o;
  wire         out_last_o;
  wire         frame_active_o;
  wire         overflow_o;

  // packed cases L H NN M, all ones past the last one
  logic [19:0] cases [MAX_CASES];
  // {last, upper is free count, lower is free count, data}
  logic [66:0] exp_q [$];
  logic [31:0] last_free  = '0;
  integer      seed       = 41;
  integer      num_cases  = 0;
  logic [1:0]  ready_mode = 2'd0;

  adc_capture_top u_dut (.*);

  // 40 ns period
  always #20 clk_245_76MHz = ~clk_245_76MHz;

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
    if (got !== want) begin
      stop_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, want));
    end
  endtask

  // one clock on, then ready for the new cycle
  task automatic next_cycle();
    @(posedge clk_245_76MHz);
    #2;
    out_ready_i = (ready_mode == 2'd0) || (ready_mode == 2'd1 && ($random(seed) % 2) != 0);
  endtask

  // expected half for sample value s at frame index k
  function automatic logic [31:0] half_value(input logic [1:0] route, input logic [15:0] s,
                                             input int k);
    case (route)
      2'd0:    return {s, ~s};
      2'd1:    return {s ^ 16'h5a5a, s + 16'h0100};
      2'd2:    return 32'(k);
      default: return 32'h0;
    endcase
  endfunction

  // valid and ready high here means a transfer on the next edge
  always @(negedge clk_245_76MHz) begin
    logic [66:0] word;
    logic [31:0] got;
    if (!cpu_reset && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        stop_run("a word came out of the stream with none expected");
      end else begin
        word = exp_q.pop_front();
        compare_value("out_last_o", 64'(out_last_o), 64'(word[66]));
        for (int h = 0; h < 2; h++) begin
          got = out_data_o[32*h +: 32];
          // free count halves only have to keep rising
          if (!word[64+h]) begin
            compare_value($sformatf("out_data_o[%0d:%0d]", 32*h+31, 32*h),
                          64'(got), 64'(word[32*h +: 32]));
          end else if (got <= last_free) begin
            stop_run($sformatf("free count 0x%0h did not rise above 0x%0h", got, last_free));
          end else begin
            last_free = got;
          end
        end
      end
    end
  end

  // cycle budget per case plus the reset
  initial begin
    wait (num_cases != 0);
    repeat (num_cases * CASE_CYCLES + 10) @(posedge clk_245_76MHz);
    stop_run("timeout: the stream did not deliver all frames in time");
  end

  initial begin
    logic [19:0] c;
    logic [15:0] smp;
    logic        ovf_exp;
    int          n;
    int          kept;
    int          total;
    smp     = 16'h0100;
    ovf_exp = 1'b0;
    total   = 0;
    for (int i = 0; i < MAX_CASES; i++) begin
      cases[i] = '1;
    end
    $readmemh("verif/capture_cases.txt", cases);
    while (total < MAX_CASES && cases[total] !== '1) begin
      total++;
    end
    if (total == 0) begin
      stop_run("no test cases were read from the case file");
    end
    num_cases = total;
    repeat (10) next_cycle();
    // outputs held clear by reset
    compare_value("out_valid_o", 64'(out_valid_o), 64'(0));
    compare_value("frame_active_o", 64'(frame_active_o), 64'(0));
    compare_value("overflow_o", 64'(overflow_o), 64'(0));
    cpu_reset = 1'b0;
    for (int i = 0; i < total; i++) begin
      c            = cases[i];
      n            = int'(c[11:4]);
      // stalled frame keeps the header in the register and fills the FIFO with samples
      kept         = (c[1:0] == 2'd2 && n > stream_pkg::FIFO_DEPTH) ? stream_pkg::FIFO_DEPTH : n;
      route_word_i = {2'b00, c[13:12], 2'b00, c[17:16]};
      ready_mode   = c[1:0];
      // header opens the frame with a zero sample count
      exp_q.push_back({3'b010, 32'h0, 32'h0});
      for (int k = 0; k < kept; k++) begin
        exp_q.push_back({1'b0, c[13:12] == 2'd3, c[17:16] == 2'd3,
                         half_value(c[13:12], smp + 16'(k), k),
                         half_value(c[17:16], smp + 16'(k), k)});
      end
      exp_q.push_back({3'b110, 32'h0, 32'(kept)});
      ovf_exp    = ovf_exp || (n > kept);
      enable_i   = 1'b1;
      // frame_active marks the header cycle, run follows one cycle later
      do begin
        next_cycle();
      end while (!frame_active_o);
      next_cycle();
      for (int k = 0; k < n; k++) begin
        // frame stays open while samples arrive
        compare_value("frame_active_o", 64'(frame_active_o), 64'(1));
        adc_i_i        = smp;
        adc_q_i        = ~smp;
        dac_i_i        = smp ^ 16'h5a5a;
        dac_q_i        = smp + 16'h0100;
        sample_valid_i = 1'b1;
        smp            = smp + 16'h0001;
        next_cycle();
      end
      sample_valid_i = 1'b0;
      enable_i       = 1'b0;
      // trailer waits on the full FIFO until ready comes back
      if (ready_mode == 2'd2) begin
        repeat (8) next_cycle();
        ready_mode = 2'd0;
      end
      while (exp_q.size() != 0 || frame_active_o) begin
        next_cycle();
      end
      compare_value("overflow_o", 64'(overflow_o), 64'(ovf_exp));
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/adc_capture_assert.sv
`timescale 1ns/1ns
`default_nettype none

module adc_capture_assert (
  input wire                          clk_245_76MHz,
  input wire                          cpu_reset,
  input wire                          fifo_empty_i,
  input wire                          pop_o,
  input wire                          out_ready_i,
  input wire                          out_valid_o,
  input wire                          out_last_o,
  input wire [stream_pkg::WORD_W-1:0] out_data_o
);

  // stalled word holds valid, data and last
  assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o) && $stable(out_last_o))
    else $error("output word changed while stalled");

  // no pop from an empty FIFO
  assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset) !(pop_o && fifo_empty_i))
    else $error("pop while FIFO empty");

  // reset clears valid
  assert property (@(posedge clk_245_76MHz) cpu_reset |=> !out_valid_o)
    else $error("out_valid_o high during reset");

endmodule

bind stream_out_stage adc_capture_assert u_assert (.*);

`default_nettype wire

//--- hdl/adc_capture_top.sv
`timescale 1ns/1ns
`default_nettype none

module adc_capture_top (
  input  wire                             clk_245_76MHz,
  input  wire                             cpu_reset,
  input  wire                             enable_i,
  input  wire [7:0]                       route_word_i,
  input  wire [capture_pkg::SAMPLE_W-1:0] adc_i_i,
  input  wire [capture_pkg::SAMPLE_W-1:0] adc_q_i,
  input  wire [capture_pkg::SAMPLE_W-1:0] dac_i_i,
  input  wire [capture_pkg::SAMPLE_W-1:0] dac_q_i,
  input  wire                             sample_valid_i,
  input  wire                             out_ready_i,
  output wire [stream_pkg::WORD_W-1:0]    out_data_o,
  output wire                             out_valid_o,
  output wire                             out_last_o,
  output wire                             frame_active_o,
  output wire                             overflow_o
);

  // framer to FIFO
  wire                          push;
  wire [stream_pkg::WORD_W-1:0] push_data;
  wire                          push_last;
  wire                          fifo_full;

  // FIFO to output stage
  wire                          fifo_empty;
  wire [stream_pkg::WORD_W-1:0] head_data;
  wire                          head_last;
  wire                          pop;

  capture_framer u_framer (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .enable_i       (enable_i),
    .route_word_i   (route_word_i),
    .adc_i_i        (adc_i_i),
    .adc_q_i        (adc_q_i),
    .dac_i_i        (dac_i_i),
    .dac_q_i        (dac_q_i),
    .sample_valid_i (sample_valid_i),
    .fifo_full_i    (fifo_full),
    .push_o         (push),
    .push_data_o    (push_data),
    .push_last_o    (push_last),
    .frame_active_o (frame_active_o),
    .overflow_o     (overflow_o)
  );

  sample_fifo #(
    .DEPTH (stream_pkg::FIFO_DEPTH)
  ) u_fifo (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .push_i        (push),
    .push_data_i   (push_data),
    .push_last_i   (push_last),
    .pop_i         (pop),
    .full_o        (fifo_full),
    .empty_o       (fifo_empty),
    .head_data_o   (head_data),
    .head_last_o   (head_last)
  );

  stream_out_stage u_out (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .fifo_empty_i  (fifo_empty),
    .head_data_i   (head_data),
    .head_last_i   (head_last),
    .out_ready_i   (out_ready_i),
    .pop_o         (pop),
    .out_data_o    (out_data_o),
    .out_last_o    (out_last_o),
    .out_valid_o   (out_valid_o)
  );

endmodule

`default_nettype wire

//--- hdl/stream_out_stage.sv
`timescale 1ns/1ns
`default_nettype none

module stream_out_stage (
  input  wire                           clk_245_76MHz,
  input  wire                           cpu_reset,
  input  wire                           fifo_empty_i,
  input  wire [stream_pkg::WORD_W-1:0]  head_data_i,
  input  wire                           head_last_i,
  input  wire                           out_ready_i,
  output logic                          pop_o,
  output logic [stream_pkg::WORD_W-1:0] out_data_o,
  output logic                          out_last_o,
  output logic                          out_valid_o
);

  logic load;

  // refill when the register is free or its word leaves this cycle
  assign load  = !fifo_empty_i && (!out_valid_o || out_ready_i);
  // pop together with the load
  assign pop_o = load;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      out_valid_o <= 1'b0;
    end else if (load) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      // word taken and nothing behind it
      out_valid_o <= 1'b0;
    end
  end

  // data and last only change on a load, so they hold under back-pressure
  always_ff @(posedge clk_245_76MHz) begin
    if (load) begin
      out_data_o <= head_data_i;
      out_last_o <= head_last_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/sample_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sample_fifo #(
  parameter int DEPTH = stream_pkg::FIFO_DEPTH
) (
  input  wire                           clk_245_76MHz,
  input  wire                           cpu_reset,
  input  wire                           push_i,
  input  wire [stream_pkg::WORD_W-1:0]  push_data_i,
  input  wire                           push_last_i,
  input  wire                           pop_i,
  output logic                          full_o,
  output logic                          empty_o,
  output logic [stream_pkg::WORD_W-1:0] head_data_o,
  output logic                          head_last_o
);

  localparam int AW = $clog2(DEPTH);

  // last flag stored in the top bit of each entry
  logic [stream_pkg::WORD_W:0] mem [DEPTH];
  logic [AW-1:0]               wr_ptr;
  logic [AW-1:0]               rd_ptr;
  logic [AW:0]                 count;
  logic                        do_push;
  logic                        do_pop;

  assign full_o  = (count == (AW + 1)'(DEPTH));
  assign empty_o = (count == '0);

  // push while full is dropped here, framer handles the loss
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // first-word-fall-through head
  assign {head_last_o, head_data_o} = mem[rd_ptr];

  always_ff @(posedge clk_245_76MHz) begin
    if (do_push) begin
      mem[wr_ptr] <= {push_last_i, push_data_i};
    end
  end

  // pointers wrap on their own for a power-of-two depth
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/capture_framer.sv
`timescale 1ns/1ns
`default_nettype none

module capture_framer (
  input  wire                             clk_245_76MHz,
  input  wire                             cpu_reset,
  input  wire                             enable_i,
  input  wire [7:0]                       route_word_i,
  input  wire [capture_pkg::SAMPLE_W-1:0] adc_i_i,
  input  wire [capture_pkg::SAMPLE_W-1:0] adc_q_i,
  input  wire [capture_pkg::SAMPLE_W-1:0] dac_i_i,
  input  wire [capture_pkg::SAMPLE_W-1:0] dac_q_i,
  input  wire                             sample_valid_i,
  input  wire                             fifo_full_i,
  output logic                            push_o,
  output logic [stream_pkg::WORD_W-1:0]   push_data_o,
  output logic                            push_last_o,
  output logic                            frame_active_o,
  output logic                            overflow_o
);

  localparam int SETTLE_W = $clog2(capture_pkg::DDS_LATENCY + 1);

  capture_pkg::capture_state_e state;
  capture_pkg::route_sel_e     route_lo_q;
  capture_pkg::route_sel_e     route_hi_q;

  logic                            enable_r;
  logic [SETTLE_W-1:0]             settle_cnt;
  logic [capture_pkg::COUNT_W-1:0] sample_count;
  logic [capture_pkg::COUNT_W-1:0] free_count;
  logic [capture_pkg::IQ_W-1:0]    adc_iq;
  logic [capture_pkg::IQ_W-1:0]    dac_iq;
  logic                            marker;
  logic                            sample_push;

  // pick the source for one half of a data word
  function automatic logic [capture_pkg::IQ_W-1:0] route_mux(
    input capture_pkg::route_sel_e        sel,
    input logic [capture_pkg::IQ_W-1:0]    a_iq,
    input logic [capture_pkg::IQ_W-1:0]    d_iq,
    input logic [capture_pkg::COUNT_W-1:0] smp_cnt,
    input logic [capture_pkg::COUNT_W-1:0] free_cnt
  );
    case (sel)
      capture_pkg::ROUTE_ADC_IQ:       return a_iq;
      capture_pkg::ROUTE_DAC_IQ:       return d_iq;
      capture_pkg::ROUTE_SAMPLE_COUNT: return smp_cnt;
      default:                         return free_cnt;
    endcase
  endfunction

  assign adc_iq = {adc_i_i, adc_q_i};
  assign dac_iq = {dac_i_i, dac_q_i};

  // route word takes effect one cycle after it changes
  always_ff @(posedge clk_245_76MHz) begin
    route_lo_q <= capture_pkg::route_sel_e'(route_word_i[capture_pkg::ROUTE_LO_LSB +: 2]);
    route_hi_q <= capture_pkg::route_sel_e'(route_word_i[capture_pkg::ROUTE_HI_LSB +: 2]);
  end

  // header and trailer share one word layout
  assign marker      = (state == capture_pkg::CAP_HEADER) || (state == capture_pkg::CAP_TRAILER);
  // samples are taken in run and through the settle window
  assign sample_push = sample_valid_i &&
                       ((state == capture_pkg::CAP_RUN) || (state == capture_pkg::CAP_SETTLE));

  assign push_o         = marker || sample_push;
  assign push_last_o    = (state == capture_pkg::CAP_TRAILER);
  assign frame_active_o = (state != capture_pkg::CAP_IDLE);
  // markers carry {free count, sample count}
  assign push_data_o    = marker ? {free_count, sample_count} :
                          {route_mux(route_hi_q, adc_iq, dac_iq, sample_count, free_count),
                           route_mux(route_lo_q, adc_iq, dac_iq, sample_count, free_count)};

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      state        <= capture_pkg::CAP_IDLE;
      enable_r     <= 1'b0;
      settle_cnt   <= '0;
      sample_count <= '0;
      free_count   <= '0;
      overflow_o   <= 1'b0;
    end else begin
      // single synchronizer stage on the enable
      enable_r   <= enable_i;
      free_count <= free_count + 1'b1;

      // sample count only moves on words the FIFO took
      if (sample_push && !fifo_full_i) begin
        sample_count <= sample_count + 1'b1;
      end
      // dropped sample, sticky until reset
      if (sample_push && fifo_full_i) begin
        overflow_o <= 1'b1;
      end

      case (state)
        capture_pkg::CAP_IDLE: begin
          if (enable_r) begin
            // count starts over so the header reports zero
            sample_count <= '0;
            state        <= capture_pkg::CAP_HEADER;
          end
        end
        capture_pkg::CAP_HEADER: begin
          // wait here while full, the header must not be lost
          if (!fifo_full_i) begin
            state <= capture_pkg::CAP_RUN;
          end
        end
        capture_pkg::CAP_RUN: begin
          if (!enable_r) begin
            settle_cnt <= SETTLE_W'(capture_pkg::DDS_LATENCY);
            state      <= capture_pkg::CAP_SETTLE;
          end
        end
        capture_pkg::CAP_SETTLE: begin
          settle_cnt <= settle_cnt - 1'b1;
          if (settle_cnt == SETTLE_W'(1)) begin
            state <= capture_pkg::CAP_TRAILER;
          end
        end
        capture_pkg::CAP_TRAILER: begin
          // trailer also holds until the FIFO has room
          if (!fifo_full_i) begin
            state <= capture_pkg::CAP_IDLE;
          end
        end
        default: begin
          state <= capture_pkg::CAP_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/stream_pkg.sv
`default_nettype none

package stream_pkg;

  // width of one word on the output stream
  localparam int WORD_W = 64;

  // default sample FIFO depth in words
  localparam int FIFO_DEPTH = 16;

  // pointer width that goes with the default depth
  localparam int FIFO_ADDR_W = 4;

endpackage

`default_nettype wire

//--- hdl/capture_pkg.sv
`default_nettype none

package capture_pkg;

  // one I or Q sample from the converters
  localparam int SAMPLE_W = 16;
  // I in the upper half, Q in the lower half
  localparam int IQ_W = 2 * SAMPLE_W;
  // sample count and free-running cycle count
  localparam int COUNT_W = 32;

  // cycles the signal chain needs after the enable drops
  localparam int DDS_LATENCY = 2;

  // field positions in the route control word
  localparam int ROUTE_LO_LSB = 0;
  localparam int ROUTE_HI_LSB = 4;

  // source of one 32-bit half of a data word
  typedef enum logic [1:0] {
    ROUTE_ADC_IQ       = 2'b00,
    ROUTE_DAC_IQ       = 2'b01,
    ROUTE_SAMPLE_COUNT = 2'b10,
    ROUTE_FREE_COUNT   = 2'b11
  } route_sel_e;

  // framer FSM
  typedef enum logic [2:0] {
    CAP_IDLE,
    CAP_HEADER,
    CAP_RUN,
    CAP_SETTLE,
    CAP_TRAILER
  } capture_state_e;

endpackage

`default_nettype wire
